// File: vector_pkg.sv
package vector_pkg;

  // bf16 element layout
  localparam int BF16_W = 16;
  localparam int EXP_W  = 8;
  localparam int FRAC_W = 7;

  // guard, round, sticky
  localparam int GRS_W = 3;

  // vector shape
  localparam int LANES = 4;
  localparam int VL_W  = 3;   // holds 0..LANES

  // special encodings
  localparam logic [EXP_W-1:0] EXP_ALL1 = {EXP_W{1'b1}};

  localparam logic [BF16_W-1:0] QNAN    = 16'h7FC0;
  localparam logic [BF16_W-1:0] POS_INF = 16'h7F80;
  localparam logic [BF16_W-1:0] NEG_INF = 16'hFF80;

endpackage

// File: bf16_addsub.sv
module bf16_addsub (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          enable,
  input  logic                          sub,
  input  logic [vector_pkg::BF16_W-1:0] port_a,
  input  logic [vector_pkg::BF16_W-1:0] port_b,
  output logic [vector_pkg::BF16_W-1:0] result,
  output logic                          overflow
);

  localparam int SIG_W  = vector_pkg::FRAC_W + 1;    // hidden bit + fraction
  localparam int EXT_W  = SIG_W + vector_pkg::GRS_W;  // significand with grs room
  localparam int SUM_W  = EXT_W + 1;                  // one carry bit on top
  localparam int LZ_W   = $clog2(SUM_W + 1);
  localparam int EXPX_W = vector_pkg::EXP_W + 2;      // sign and headroom for over/underflow

  function automatic logic [vector_pkg::EXP_W-1:0] exp_of(
    input logic [vector_pkg::BF16_W-1:0] x
  );
    return x[vector_pkg::BF16_W-2 -: vector_pkg::EXP_W];
  endfunction

  function automatic logic [vector_pkg::FRAC_W-1:0] frac_of(
    input logic [vector_pkg::BF16_W-1:0] x
  );
    return x[vector_pkg::FRAC_W-1:0];
  endfunction

  function automatic logic is_nan(input logic [vector_pkg::BF16_W-1:0] x);
    return (exp_of(x) == vector_pkg::EXP_ALL1) && (frac_of(x) != '0);
  endfunction

  function automatic logic is_inf(input logic [vector_pkg::BF16_W-1:0] x);
    return (exp_of(x) == vector_pkg::EXP_ALL1) && (frac_of(x) == '0);
  endfunction

  function automatic logic [vector_pkg::BF16_W-1:0] inf_of(input logic s);
    return s ? vector_pkg::NEG_INF : vector_pkg::POS_INF;
  endfunction

  // subnormals read as zero (DAZ)
  function automatic logic [SIG_W-1:0] sig_of(input logic [vector_pkg::BF16_W-1:0] x);
    return (exp_of(x) == '0) ? '0 : {1'b1, frac_of(x)};
  endfunction

  // right shift, everything shifted out ORed into the lsb
  function automatic logic [EXT_W-1:0] align(
    input logic [EXT_W-1:0]             x,
    input logic [vector_pkg::EXP_W-1:0] shamt
  );
    logic [EXT_W-1:0] y;
    logic [EXT_W-1:0] lost;
    if (shamt >= EXT_W) begin
      y    = '0;
      y[0] = |x;
    end else begin
      y    = x >> shamt;
      lost = x & ~({EXT_W{1'b1}} << shamt);
      y[0] = y[0] | (|lost);
    end
    return y;
  endfunction

  function automatic logic [LZ_W-1:0] lzc(input logic [SUM_W-1:0] x);
    logic [LZ_W-1:0] n;
    logic            found;
    n     = LZ_W'(SUM_W);
    found = 1'b0;
    for (int i = SUM_W - 1; i >= 0; i--) begin
      if (!found && x[i]) begin
        n     = LZ_W'(SUM_W - 1 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  // stage 1: classify, align, add

  logic                          sign_a, sign_b;
  logic                          s1n_special;
  logic [vector_pkg::BF16_W-1:0] s1n_special_res;

  assign sign_a = port_a[vector_pkg::BF16_W-1];
  assign sign_b = port_b[vector_pkg::BF16_W-1] ^ sub;  // a - b is a + (-b)

  always_comb begin
    s1n_special     = 1'b1;
    s1n_special_res = vector_pkg::QNAN;
    if (is_nan(port_a) || is_nan(port_b)) begin
      s1n_special_res = vector_pkg::QNAN;
    end else if (is_inf(port_a) && is_inf(port_b)) begin
      // inf - inf is invalid
      s1n_special_res = (sign_a ^ sign_b) ? vector_pkg::QNAN : inf_of(sign_a);
    end else if (is_inf(port_a)) begin
      s1n_special_res = inf_of(sign_a);
    end else if (is_inf(port_b)) begin
      s1n_special_res = inf_of(sign_b);
    end else begin
      s1n_special = 1'b0;
    end
  end

  logic [vector_pkg::EXP_W-1:0] e_a, e_b, big_exp, small_exp;
  logic [SIG_W-1:0]             m_a, m_b;
  logic [EXT_W-1:0]             big_sig, small_sig, small_al;
  logic                         swap, big_sign, small_sign;
  logic [SUM_W-1:0]             s1n_mag;

  assign e_a = exp_of(port_a);
  assign e_b = exp_of(port_b);
  assign m_a = sig_of(port_a);
  assign m_b = sig_of(port_b);

  assign swap = (e_b > e_a) || ((e_b == e_a) && (m_b > m_a));  // b is larger

  assign big_exp    = swap ? e_b : e_a;
  assign small_exp  = swap ? e_a : e_b;
  assign big_sig    = swap ? {m_b, {vector_pkg::GRS_W{1'b0}}} : {m_a, {vector_pkg::GRS_W{1'b0}}};
  assign small_sig  = swap ? {m_a, {vector_pkg::GRS_W{1'b0}}} : {m_b, {vector_pkg::GRS_W{1'b0}}};
  assign big_sign   = swap ? sign_b : sign_a;
  assign small_sign = swap ? sign_a : sign_b;

  assign small_al = align(small_sig, big_exp - small_exp);

  // larger minus smaller never goes negative
  assign s1n_mag = (big_sign ^ small_sign) ? ({1'b0, big_sig} - {1'b0, small_al})
                                           : ({1'b0, big_sig} + {1'b0, small_al});

  logic                          s1_v;
  logic                          s1_special;
  logic [vector_pkg::BF16_W-1:0] s1_special_res;
  logic [SUM_W-1:0]              s1_mag;
  logic [vector_pkg::EXP_W-1:0]  s1_exp;
  logic                          s1_sign;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_v <= 1'b0;
    end else begin
      s1_v <= enable;
    end
  end

  always_ff @(posedge CLK) begin
    if (enable) begin  // hold payload while the lane is idle
      s1_special     <= s1n_special;
      s1_special_res <= s1n_special_res;
      s1_mag         <= s1n_mag;
      s1_exp         <= big_exp;
      s1_sign        <= big_sign;
    end
  end

  // stage 2: normalize, round, pack

  logic [LZ_W-1:0]               lz, shl;
  logic [SUM_W-1:0]              norm;
  logic [EXPX_W-1:0]             exp_n, exp_post;
  logic [SIG_W-1:0]              sig_keep, sig_rnd;
  logic                          guard, rnd, stk, inc, rnd_carry;
  logic [vector_pkg::BF16_W-1:0] s2n_out;
  logic                          s2n_ovf;

  assign lz  = lzc(s1_mag);
  assign shl = lz - 1'b1;  // msb lands on bit EXT_W-1

  always_comb begin
    norm  = s1_mag;
    exp_n = EXPX_W'(s1_exp);
    if (s1_mag[SUM_W-1]) begin
      // carry out, shift right once keeping sticky
      norm    = s1_mag >> 1;
      norm[0] = norm[0] | s1_mag[0];
      exp_n   = exp_n + 1'b1;
    end else if (s1_mag != '0) begin
      norm  = s1_mag << shl;
      exp_n = exp_n - EXPX_W'(shl);  // may go to zero or below
    end
  end

  assign sig_keep = norm[vector_pkg::GRS_W +: SIG_W];
  assign guard    = norm[2];
  assign rnd      = norm[1];
  assign stk      = norm[0];
  assign inc      = guard & (rnd | stk | sig_keep[0]);  // ties to even

  assign {rnd_carry, sig_rnd} = {1'b0, sig_keep} + inc;
  // on carry sig_rnd wraps to zero, which is the right fraction for 1.0 * 2^(e+1)
  assign exp_post = exp_n + rnd_carry;

  always_comb begin
    s2n_out = '0;
    s2n_ovf = 1'b0;
    if (s1_special) begin
      s2n_out = s1_special_res;
    end else if (s1_mag == '0) begin
      s2n_out = '0;  // exact cancellation is +0
    end else if (exp_post[EXPX_W-1] || exp_post == '0) begin
      s2n_out = {s1_sign, {(vector_pkg::BF16_W-1){1'b0}}};  // FTZ
    end else if (exp_post >= EXPX_W'(vector_pkg::EXP_ALL1)) begin
      s2n_out = inf_of(s1_sign);
      s2n_ovf = 1'b1;
    end else begin
      s2n_out = {s1_sign, exp_post[vector_pkg::EXP_W-1:0], sig_rnd[vector_pkg::FRAC_W-1:0]};
    end
  end

  logic                          s2_v;
  logic [vector_pkg::BF16_W-1:0] s2_out;
  logic                          s2_ovf;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s2_v <= 1'b0;
    end else begin
      s2_v <= s1_v;
    end
  end

  always_ff @(posedge CLK) begin
    if (s1_v) begin
      s2_out <= s2n_out;
      s2_ovf <= s2n_ovf;
    end
  end

  // idle lanes read as zero
  assign result   = s2_v ? s2_out : '0;
  assign overflow = s2_v & s2_ovf;

endmodule

// File: vaddsub_issue.sv
module vaddsub_issue (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        enable,
  input  logic [vector_pkg::VL_W-1:0] vl,
  input  logic [vector_pkg::LANES-1:0] lane_mask,
  output logic [vector_pkg::LANES-1:0] lane_en,
  output logic                        out_valid
);

  logic [1:0] valid_q;  // one bit per lane stage

  // lane i runs when issued, inside vl and not masked
  always_comb begin
    for (int i = 0; i < vector_pkg::LANES; i++) begin
      lane_en[i] = enable & lane_mask[i] & (i < int'(vl));
    end
  end

  // operation valid follows the strobe, not the lanes,
  // so vl of 0 still gives a pulse
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[0], enable};
    end
  end

  assign out_valid = valid_q[1];  // lines up with the lane result registers

endmodule

// File: fp_status_flags.sv
module fp_status_flags (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic [vector_pkg::LANES-1:0] lane_ovf,
  input  logic                         clear_flags,
  output logic                         overflow_flag
);

  logic any_ovf;

  assign any_ovf = |lane_ovf;  // lanes already gate with their valid

  // sticky, a new overflow beats a clear in the same cycle
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      overflow_flag <= 1'b0;
    end else if (any_ovf) begin
      overflow_flag <= 1'b1;
    end else if (clear_flags) begin
      overflow_flag <= 1'b0;
    end
  end

endmodule

// File: vaddsub.sv
module vaddsub (
  input  logic                                            CLK,
  input  logic                                            nRST,
  input  logic                                            enable,
  input  logic                                            sub,
  input  logic [vector_pkg::VL_W-1:0]                     vl,
  input  logic [vector_pkg::LANES-1:0]                    lane_mask,
  input  logic [vector_pkg::LANES*vector_pkg::BF16_W-1:0] vec_a,
  input  logic [vector_pkg::LANES*vector_pkg::BF16_W-1:0] vec_b,
  input  logic                                            clear_flags,
  output logic [vector_pkg::LANES*vector_pkg::BF16_W-1:0] vec_out,
  output logic                                            out_valid,
  output logic [vector_pkg::LANES-1:0]                    overflow,
  output logic                                            overflow_flag
);

  logic [vector_pkg::LANES-1:0] lane_en;

  vaddsub_issue issue0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .enable    (enable),
    .vl        (vl),
    .lane_mask (lane_mask),
    .lane_en   (lane_en),
    .out_valid (out_valid)
  );

  // lane i owns bits 16i .. 16i+15 of each vector
  for (genvar i = 0; i < vector_pkg::LANES; i++) begin : gen_lane
    bf16_addsub lane (
      .CLK      (CLK),
      .nRST     (nRST),
      .enable   (lane_en[i]),
      .sub      (sub),            // shared across lanes
      .port_a   (vec_a[i*vector_pkg::BF16_W +: vector_pkg::BF16_W]),
      .port_b   (vec_b[i*vector_pkg::BF16_W +: vector_pkg::BF16_W]),
      .result   (vec_out[i*vector_pkg::BF16_W +: vector_pkg::BF16_W]),
      .overflow (overflow[i])
    );
  end

  fp_status_flags flags0 (
    .CLK           (CLK),
    .nRST          (nRST),
    .lane_ovf      (overflow),
    .clear_flags   (clear_flags),
    .overflow_flag (overflow_flag)
  );

endmodule

// File: vaddsub_props.sv
module vaddsub_props (
  input logic                                            CLK,
  input logic                                            nRST,
  input logic                                            enable,
  input logic                                            clear_flags,
  input logic [vector_pkg::LANES-1:0]                    lane_en,
  input logic [vector_pkg::LANES*vector_pkg::BF16_W-1:0] vec_out,
  input logic                                            out_valid,
  input logic [vector_pkg::LANES-1:0]                    overflow,
  input logic                                            overflow_flag
);
  timeunit 1ns;
  timeprecision 1ps;

  // one lane enable spread over that lane's 16 result bits
  function automatic logic [vector_pkg::LANES*vector_pkg::BF16_W-1:0] lane_bits(
    input logic [vector_pkg::LANES-1:0] en
  );
    logic [vector_pkg::LANES*vector_pkg::BF16_W-1:0] m;
    m = '0;
    for (int i = 0; i < vector_pkg::LANES; i++) begin
      m[i*vector_pkg::BF16_W +: vector_pkg::BF16_W] = {vector_pkg::BF16_W{en[i]}};
    end
    return m;
  endfunction

  valid_latency: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid == $past(enable, 2))
    else $error("out_valid is not enable delayed by two cycles");

  idle_lanes_zero: assert property (@(posedge CLK) disable iff (!nRST)
    (vec_out & ~lane_bits($past(lane_en, 2))) == '0)
    else $error("a disabled lane drives a nonzero result");

  ovf_needs_valid: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid || (overflow == '0))
    else $error("overflow bit high outside the out_valid cycle");

  flag_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    $fell(overflow_flag) |-> $past(clear_flags))
    else $error("overflow_flag fell without clear_flags");

endmodule

bind vaddsub vaddsub_props props0 (
  .CLK           (CLK),
  .nRST          (nRST),
  .enable        (enable),
  .clear_flags   (clear_flags),
  .lane_en       (lane_en),
  .vec_out       (vec_out),
  .out_valid     (out_valid),
  .overflow      (overflow),
  .overflow_flag (overflow_flag)
);

// File: tb_vaddsub.sv
module tb_vaddsub;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LN         = vector_pkg::LANES;
  localparam int EW         = vector_pkg::BF16_W;
  localparam int VW         = vector_pkg::VL_W;
  localparam int VEC_W      = LN * EW;
  localparam int ROWS       = 8;
  localparam int WAIT_LIMIT = 10;  // cycles
  localparam int SWEEP_ROW  = 5;   // overflowing lanes show the ovf gating

  logic             CLK, nRST, enable, sub, clear_flags;
  logic [VW-1:0]    vl;
  logic [LN-1:0]    lane_mask, overflow;
  logic [VEC_W-1:0] vec_a, vec_b, vec_out;
  logic             out_valid, overflow_flag;

  // stimulus and expected results with lane 0 in the low 16 bits
  string            t_name [ROWS];
  logic             t_sub  [ROWS];
  logic [VW-1:0]    t_vl   [ROWS];
  logic [LN-1:0]    t_mask [ROWS];
  logic [VEC_W-1:0] t_a [ROWS], t_b [ROWS], t_res [ROWS];
  logic [LN-1:0]    t_ovf  [ROWS];

  int          mismatches, timeouts;
  logic [31:0] lfsr_state;

  vaddsub dut0 (.*);

  always #10 CLK = ~CLK;

  task automatic set_row(input int r, input string name, input logic s, input logic [VW-1:0] v,
                         input logic [LN-1:0] m, input logic [VEC_W-1:0] a, b, res,
                         input logic [LN-1:0] ovf);
    t_name[r] = name;
    t_sub[r]  = s;
    t_vl[r]   = v;
    t_mask[r] = m;
    t_a[r]    = a;
    t_b[r]    = b;
    t_res[r]  = res;
    t_ovf[r]  = ovf;
  endtask

  task automatic load_table();
    set_row(0, "add_basic", 0, 4, 4'hF, 64'h3F80_3F80_3F80_3F80,
            64'h3580_3F00_4000_3F80, 64'h3F80_3FC0_4040_4000, 4'h0);
    set_row(1, "sub_basic", 1, 4, 4'hF, 64'h4000_3F80_4040_3FC0,
            64'hBF80_4000_4040_3F00, 64'h4040_BF80_0000_3F80, 4'h0);
    set_row(2, "round_even", 0, 4, 4'hF, 64'h3FFF_3F80_3F81_3F80,
            64'h3B80_3B81_3B80_3B80, 64'h4000_3F81_3F82_3F80, 4'h0);
    set_row(3, "specials", 0, 4, 4'hF, 64'h0040_7F80_3F80_7F81,
            64'h3F80_3F80_FFC0_3F80, 64'h3F80_7F80_7FC0_7FC0, 4'h0);
    set_row(4, "inf_sub", 1, 4, 4'hF, 64'hFF80_3F80_FF80_7F80,
            64'h7F80_FF80_3F80_7F80, 64'hFF80_7F80_FF80_7FC0, 4'h0);
    set_row(5, "overflow", 0, 4, 4'hF, 64'h3F80_0100_FF7F_7F7F,
            64'h3F80_80C0_FF7F_7F7F, 64'h4000_0000_FF80_7F80, 4'h3);
    set_row(6, "vl_zero", 0, 0, 4'hF, t_a[0], t_b[0], 64'h0, 4'h0);
    set_row(7, "masked", 0, 3, 4'hA, t_a[0], t_b[0], 64'h0000_0000_4040_0000, 4'h0);
  endtask

  // galois lfsr stepped once per bit taken
  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic drive_op(input logic s, input logic [VW-1:0] v, input logic [LN-1:0] m,
                          input logic [VEC_W-1:0] a, b);
    enable    <= 1'b1;
    sub       <= s;
    vl        <= v;
    lane_mask <= m;
    vec_a     <= a;
    vec_b     <= b;
  endtask

  task automatic wait_valid(input string name);
    int n;
    n = 0;
    @(negedge CLK);
    while (!out_valid && n < WAIT_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    assert (out_valid) else begin
      $display("ERROR: %s got no out_valid within %0d cycles", name, WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic check_outputs(input string name, input logic [VEC_W-1:0] exp_res,
                               input logic [LN-1:0] exp_ovf);
    for (int i = 0; i < LN; i++) begin
      assert (vec_out[i*EW +: EW] == exp_res[i*EW +: EW]) else begin
        $display("Mismatch %s lane %0d: expected %h, actual %h", name, i,
                 exp_res[i*EW +: EW], vec_out[i*EW +: EW]);
        mismatches++;
      end
    end
    assert (overflow == exp_ovf) else begin
      $display("Mismatch %s overflow: expected %b, actual %b", name, exp_ovf, overflow);
      mismatches++;
    end
  endtask

  task automatic run_op(input string name, input logic s, input logic [VW-1:0] v,
                        input logic [LN-1:0] m, input logic [VEC_W-1:0] a, b, exp_res,
                        input logic [LN-1:0] exp_ovf);
    @(posedge CLK);
    drive_op(s, v, m, a, b);
    @(posedge CLK);
    enable <= 1'b0;
    wait_valid(name);
    if (out_valid) check_outputs(name, exp_res, exp_ovf);
  endtask

  task automatic run_row(input int r);
    run_op(t_name[r], t_sub[r], t_vl[r], t_mask[r], t_a[r], t_b[r], t_res[r], t_ovf[r]);
  endtask

  task automatic check_flag(input string name, input logic expected);
    assert (overflow_flag == expected) else begin
      $display("Mismatch %s: expected %b, actual %b", name, expected, overflow_flag);
      mismatches++;
    end
  endtask

  task automatic pulse_clear();
    @(posedge CLK);
    clear_flags <= 1'b1;
    @(posedge CLK);
    clear_flags <= 1'b0;
  endtask

  task automatic sticky_flag_test();
    pulse_clear();
    run_row(5);
    @(negedge CLK);  // flag sets one edge after the result cycle
    check_flag("flag_set", 1'b1);
    repeat (3) @(negedge CLK);
    check_flag("flag_holds", 1'b1);
    pulse_clear();
    @(negedge CLK);
    check_flag("flag_cleared", 1'b0);
    run_row(0);
    @(negedge CLK);
    check_flag("flag_stays_low", 1'b0);
  endtask

  // operands of the overflow row with random vl and mask
  task automatic sweep_masks(input int count);
    int               r;
    logic [LN-1:0]    m;
    logic [VW-1:0]    v;
    logic [VEC_W-1:0] exp_res;
    logic [LN-1:0]    exp_ovf;
    for (int k = 0; k < count; k++) begin
      r = random_bits(LN);
      m = r[LN-1:0];
      r = random_bits(VW) % (LN + 1);
      v = r[VW-1:0];
      exp_res = '0;
      exp_ovf = '0;
      for (int i = 0; i < LN; i++) begin
        if (m[i] && i < int'(v)) begin
          exp_res[i*EW +: EW] = t_res[SWEEP_ROW][i*EW +: EW];
          exp_ovf[i]          = t_ovf[SWEEP_ROW][i];
        end
      end
      run_op($sformatf("sweep_%0d", k), t_sub[SWEEP_ROW], v, m, t_a[SWEEP_ROW],
             t_b[SWEEP_ROW], exp_res, exp_ovf);
    end
  endtask

  // rows issued on consecutive edges and collected in order
  task automatic back_to_back();
    fork
      begin
        for (int r = 0; r < ROWS; r++) begin
          @(posedge CLK);
          drive_op(t_sub[r], t_vl[r], t_mask[r], t_a[r], t_b[r]);
        end
        @(posedge CLK);
        enable <= 1'b0;
      end
      begin
        for (int r = 0; r < ROWS; r++) begin
          wait_valid({"b2b_", t_name[r]});
          if (out_valid) check_outputs({"b2b_", t_name[r]}, t_res[r], t_ovf[r]);
        end
      end
    join
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    enable      = 1'b0;
    sub         = 1'b0;
    vl          = '0;
    lane_mask   = '0;
    vec_a       = '0;
    vec_b       = '0;
    clear_flags = 1'b0;
    lfsr_state  = 32'd90958;
    mismatches  = 0;
    timeouts    = 0;
    load_table();
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    for (int r = 0; r < ROWS; r++) run_row(r);
    sticky_flag_test();
    sweep_masks(12);
    back_to_back();
    repeat (3) @(posedge CLK);
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vaddsub.f
vector_pkg.sv
bf16_addsub.sv
vaddsub_issue.sv
fp_status_flags.sv
vaddsub.sv
vaddsub_props.sv
tb_vaddsub.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_vaddsub
FILELIST  := vaddsub.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no verdict in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
